// ==== hw/bank_tracker.sv ====
`timescale 1ns/1ps
`include "m2f_defines.svh"

module bank_tracker (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`M2F_ADDR_W-1:0] i_mem0_base,
  input  logic [`M2F_ADDR_W-1:0] i_mem0_size,
  input  logic                   i_mem0_new,
  input  logic [`M2F_ADDR_W-1:0] i_mem1_base,
  input  logic [`M2F_ADDR_W-1:0] i_mem1_size,
  input  logic                   i_mem1_new,
  input  logic                   i_advance,
  input  logic                   i_busy,
  output logic                   o_ready,
  output reader_pkg::bank_t      o_bank,
  output logic [`M2F_ADDR_W-1:0] o_count,
  output logic [`M2F_ADDR_W-1:0] o_adr,
  output logic [`M2F_ADDR_W-1:0] o_mem0_count,
  output logic [`M2F_ADDR_W-1:0] o_mem1_count,
  output logic                   o_mem0_empty,
  output logic                   o_mem1_empty
);

  logic [`M2F_ADDR_W-1:0] ptr0;
  logic [`M2F_ADDR_W-1:0] ptr1;
  logic [`M2F_ADDR_W-1:0] active_base;
  logic [`M2F_ADDR_W-1:0] active_ptr;
  logic                   sel1;

  // Words left in each bank
  assign o_mem0_count = i_mem0_size - ptr0;
  assign o_mem1_count = i_mem1_size - ptr1;
  assign o_mem0_empty = (o_mem0_count == '0);
  assign o_mem1_empty = (o_mem1_count == '0);

  assign sel1        = (o_bank == reader_pkg::BANK1);
  assign active_base = sel1 ? i_mem1_base : i_mem0_base;
  assign active_ptr  = sel1 ? ptr1 : ptr0;
  assign o_count     = sel1 ? o_mem1_count : o_mem0_count;

  // Read address wraps around the end of the memory
  assign o_adr = (active_base + active_ptr) % `M2F_MEM_WORDS;

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr0 <= '0;
      ptr1 <= '0;
    end else begin
      // New data rewinds a bank and wins over advance
      if (i_mem0_new) begin
        ptr0 <= '0;
      end else if (i_advance && !sel1) begin
        ptr0 <= ptr0 + 1'b1;
      end
      if (i_mem1_new) begin
        ptr1 <= '0;
      end else if (i_advance && sel1) begin
        ptr1 <= ptr1 + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_ready <= 1'b0;
      o_bank  <= reader_pkg::BANK0;
    end else if (!o_ready) begin
      // No bank switch while the reader is in a block
      if (!i_busy) begin
        if (!o_mem0_empty) begin
          o_ready <= 1'b1;
          o_bank  <= reader_pkg::BANK0;
        end else if (!o_mem1_empty) begin
          o_ready <= 1'b1;
          o_bank  <= reader_pkg::BANK1;
        end
      end
    end else if ((o_count == '0) && !i_advance) begin
      o_ready <= 1'b0;
    end
  end

endmodule

// ==== hw/m2f_defines.svh ====
`ifndef M2F_DEFINES_SVH
`define M2F_DEFINES_SVH

// Width of one data word
`define M2F_DATA_W 32

// Word address, bank base and bank size all use this width
`define M2F_ADDR_W 32

// Shared memory size in words, addresses wrap at this value
`define M2F_MEM_WORDS 256

// Each ping-pong half holds 2**M2F_HALF_LOG2 words
`define M2F_HALF_LOG2 3
`define M2F_HALF_DEPTH (1 << `M2F_HALF_LOG2)

`endif

// ==== hw/mem_2_ppfifo_top.sv ====
`timescale 1ns/1ps
`include "m2f_defines.svh"

module mem_2_ppfifo_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_enable,
  input  logic                   i_host_we,
  input  logic [`M2F_ADDR_W-1:0] i_host_adr,
  input  logic [`M2F_DATA_W-1:0] i_host_dat,
  input  logic [`M2F_ADDR_W-1:0] i_mem0_base,
  input  logic [`M2F_ADDR_W-1:0] i_mem0_size,
  input  logic                   i_mem0_new,
  input  logic [`M2F_ADDR_W-1:0] i_mem1_base,
  input  logic [`M2F_ADDR_W-1:0] i_mem1_size,
  input  logic                   i_mem1_new,
  output logic [`M2F_ADDR_W-1:0] o_mem0_count,
  output logic [`M2F_ADDR_W-1:0] o_mem1_count,
  output logic                   o_mem0_empty,
  output logic                   o_mem1_empty,
  output logic                   o_read_finished,
  input  logic                   i_rd_act,
  input  logic                   i_rd_stb,
  output logic                   o_rd_ready,
  output logic [`M2F_HALF_LOG2:0] o_rd_size,
  output logic [`M2F_DATA_W-1:0] o_rd_data
);

  // Memory read bus
  logic                   mem_cyc;
  logic                   mem_stb;
  logic                   mem_ack;
  logic [`M2F_ADDR_W-1:0] mem_adr;
  logic [`M2F_DATA_W-1:0] mem_dat;

  // Tracker to reader
  logic                   trk_ready;
  reader_pkg::bank_t      active_bank;
  logic [`M2F_ADDR_W-1:0] active_count;
  logic                   advance;
  logic                   busy;

  // Reader to FIFO fill side
  logic [1:0]             fifo_rdy;
  logic [1:0]             fifo_act;
  logic                   fifo_stb;
  logic [`M2F_DATA_W-1:0] fifo_dat;

  wb_sram sram0 (
    .clk(clk), .rst(rst),
    .i_host_we(i_host_we), .i_host_adr(i_host_adr), .i_host_dat(i_host_dat),
    .i_cyc(mem_cyc), .i_stb(mem_stb), .i_adr(mem_adr),
    .o_dat(mem_dat), .o_ack(mem_ack)
  );

  bank_tracker tracker0 (
    .clk(clk), .rst(rst),
    .i_mem0_base(i_mem0_base), .i_mem0_size(i_mem0_size), .i_mem0_new(i_mem0_new),
    .i_mem1_base(i_mem1_base), .i_mem1_size(i_mem1_size), .i_mem1_new(i_mem1_new),
    .i_advance(advance), .i_busy(busy),
    .o_ready(trk_ready), .o_bank(active_bank), .o_count(active_count), .o_adr(mem_adr),
    .o_mem0_count(o_mem0_count), .o_mem1_count(o_mem1_count),
    .o_mem0_empty(o_mem0_empty), .o_mem1_empty(o_mem1_empty)
  );

  mem_reader_fsm reader0 (
    .clk(clk), .rst(rst),
    .i_enable(i_enable), .i_ready(trk_ready), .i_count(active_count),
    .i_fifo_rdy(fifo_rdy), .i_mem_dat(mem_dat), .i_mem_ack(mem_ack),
    .o_advance(advance), .o_busy(busy), .o_mem_cyc(mem_cyc), .o_mem_stb(mem_stb),
    .o_fifo_act(fifo_act), .o_fifo_stb(fifo_stb), .o_fifo_dat(fifo_dat),
    .o_read_finished(o_read_finished)
  );

  ppfifo fifo0 (
    .clk(clk), .rst(rst),
    .i_wr_act(fifo_act), .i_wr_stb(fifo_stb), .i_wr_dat(fifo_dat),
    .i_rd_act(i_rd_act), .i_rd_stb(i_rd_stb),
    .o_wr_rdy(fifo_rdy), .o_rd_ready(o_rd_ready), .o_rd_size(o_rd_size),
    .o_rd_data(o_rd_data)
  );

endmodule

// ==== hw/mem_reader_fsm.sv ====
`timescale 1ns/1ps
`include "m2f_defines.svh"

module mem_reader_fsm (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_enable,
  input  logic                   i_ready,
  input  logic [`M2F_ADDR_W-1:0] i_count,
  input  logic [1:0]             i_fifo_rdy,
  input  logic [`M2F_DATA_W-1:0] i_mem_dat,
  input  logic                   i_mem_ack,
  output logic                   o_advance,
  output logic                   o_busy,
  output logic                   o_mem_cyc,
  output logic                   o_mem_stb,
  output logic [1:0]             o_fifo_act,
  output logic                   o_fifo_stb,
  output logic [`M2F_DATA_W-1:0] o_fifo_dat,
  output logic                   o_read_finished
);

  reader_pkg::reader_state_t state;
  logic [`M2F_ADDR_W-1:0]    blk_len;
  logic [`M2F_ADDR_W-1:0]    blk_cnt;
  logic [`M2F_HALF_LOG2:0]   half_cnt;
  logic                      word_ack;
  logic                      half_room;

  assign word_ack  = o_mem_stb && i_mem_ack;
  assign half_room = (o_fifo_act != 2'b00) && (half_cnt < `M2F_HALF_DEPTH);
  assign o_busy    = (state == reader_pkg::READ_DATA);

  // Data word lines up with the FIFO strobe one cycle after ack
  always_ff @(posedge clk) begin
    if (word_ack) begin
      o_fifo_dat <= i_mem_dat;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state           <= reader_pkg::IDLE;
      o_mem_cyc       <= 1'b0;
      o_mem_stb       <= 1'b0;
      o_fifo_act      <= 2'b00;
      o_fifo_stb      <= 1'b0;
      o_advance       <= 1'b0;
      o_read_finished <= 1'b0;
      half_cnt        <= '0;
      blk_len         <= '0;
      blk_cnt         <= '0;
    end else begin
      o_fifo_stb      <= 1'b0;
      o_advance       <= 1'b0;
      o_read_finished <= 1'b0;

      // Claim a free half, lower half first
      if (i_enable && (o_fifo_act == 2'b00) && (i_fifo_rdy != 2'b00)) begin
        half_cnt   <= '0;
        o_fifo_act <= i_fifo_rdy[0] ? 2'b01 : 2'b10;
      end

      case (state)
        reader_pkg::IDLE: begin
          o_mem_cyc <= 1'b0;
          o_mem_stb <= 1'b0;
          if (i_enable) begin
            state <= reader_pkg::GET_BLOCK;
          end
        end
        reader_pkg::GET_BLOCK: begin
          o_mem_cyc <= 1'b0;
          o_mem_stb <= 1'b0;
          if (!i_enable) begin
            state <= reader_pkg::IDLE;
          end else if (i_ready) begin
            blk_len <= i_count;
            blk_cnt <= '0;
            state   <= reader_pkg::READ_DATA;
          end
        end
        reader_pkg::READ_DATA: begin
          if (blk_cnt == blk_len) begin
            o_mem_cyc       <= 1'b0;
            o_mem_stb       <= 1'b0;
            o_read_finished <= 1'b1;
            state           <= reader_pkg::FINISHED;
          end else if (half_room) begin
            o_mem_cyc <= 1'b1;
            if (word_ack) begin
              // Gap cycle lets the tracker move the address
              o_mem_stb  <= 1'b0;
              o_fifo_stb <= 1'b1;
              o_advance  <= 1'b1;
              half_cnt   <= half_cnt + 1'b1;
              blk_cnt    <= blk_cnt + 1'b1;
            end else begin
              o_mem_stb <= 1'b1;
            end
          end else if (o_fifo_act != 2'b00) begin
            // Half is full, hand it over
            o_mem_cyc  <= 1'b0;
            o_mem_stb  <= 1'b0;
            o_fifo_act <= 2'b00;
            half_cnt   <= '0;
          end else begin
            // Wait for a free half
            o_mem_cyc <= 1'b0;
            o_mem_stb <= 1'b0;
          end
        end
        reader_pkg::FINISHED: begin
          o_mem_cyc <= 1'b0;
          o_mem_stb <= 1'b0;
          // Flush a partly filled half at the end of a block
          if ((o_fifo_act != 2'b00) && (half_cnt != '0)) begin
            o_fifo_act <= 2'b00;
            half_cnt   <= '0;
          end
          state <= reader_pkg::GET_BLOCK;
        end
        default: begin
          state <= reader_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

// ==== hw/ppfifo.sv ====
`timescale 1ns/1ps
`include "m2f_defines.svh"

module ppfifo (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [1:0]             i_wr_act,
  input  logic                   i_wr_stb,
  input  logic [`M2F_DATA_W-1:0] i_wr_dat,
  input  logic                   i_rd_act,
  input  logic                   i_rd_stb,
  output logic [1:0]             o_wr_rdy,
  output logic                   o_rd_ready,
  output logic [`M2F_HALF_LOG2:0] o_rd_size,
  output logic [`M2F_DATA_W-1:0] o_rd_data
);

  logic [`M2F_DATA_W-1:0]    store [2][`M2F_HALF_DEPTH];
  ppfifo_pkg::half_state_t   half_state [2];
  logic [`M2F_HALF_LOG2:0]   fill_cnt [2];
  logic [`M2F_HALF_LOG2-1:0] rd_ptr;
  logic                      rd_sel;
  logic                      drn_sel;
  logic                      draining;
  logic                      take;
  logic                      out_sel;

  assign o_wr_rdy[0] = (half_state[0] == ppfifo_pkg::EMPTY);
  assign o_wr_rdy[1] = (half_state[1] == ppfifo_pkg::EMPTY);

  // rd_sel names the oldest full half
  assign draining   = (half_state[drn_sel] == ppfifo_pkg::DRAINING);
  assign o_rd_ready = !draining && (half_state[rd_sel] == ppfifo_pkg::FULL);
  assign take       = o_rd_ready && i_rd_act;

  assign out_sel   = draining ? drn_sel : rd_sel;
  assign o_rd_size = fill_cnt[out_sel];
  assign o_rd_data = store[out_sel][rd_ptr];

  always_ff @(posedge clk) begin
    for (int h = 0; h < 2; h++) begin
      if (i_wr_stb && i_wr_act[h] && (half_state[h] == ppfifo_pkg::FILLING)) begin
        store[h][fill_cnt[h][`M2F_HALF_LOG2-1:0]] <= i_wr_dat;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int h = 0; h < 2; h++) begin
        half_state[h] <= ppfifo_pkg::EMPTY;
        fill_cnt[h]   <= '0;
      end
      rd_sel  <= 1'b0;
      drn_sel <= 1'b0;
      rd_ptr  <= '0;
    end else begin
      for (int h = 0; h < 2; h++) begin
        case (half_state[h])
          ppfifo_pkg::EMPTY: begin
            if (i_wr_act[h]) begin
              half_state[h] <= ppfifo_pkg::FILLING;
              fill_cnt[h]   <= '0;
            end
          end
          ppfifo_pkg::FILLING: begin
            if (i_wr_stb && i_wr_act[h]) begin
              fill_cnt[h] <= fill_cnt[h] + 1'b1;
            end
            if (!i_wr_act[h]) begin
              if (fill_cnt[h] == '0) begin
                half_state[h] <= ppfifo_pkg::EMPTY;
              end else begin
                half_state[h] <= ppfifo_pkg::FULL;
                // Queue behind the other half if it still waits
                if ((half_state[1-h] != ppfifo_pkg::FULL) || take) begin
                  rd_sel <= h[0];
                end
              end
            end
          end
          ppfifo_pkg::FULL: begin
            if (take && (rd_sel == h[0])) begin
              half_state[h] <= ppfifo_pkg::DRAINING;
            end
          end
          ppfifo_pkg::DRAINING: begin
            if (!i_rd_act) begin
              half_state[h] <= ppfifo_pkg::EMPTY;
            end
          end
          default: begin
            half_state[h] <= ppfifo_pkg::EMPTY;
          end
        endcase
      end

      if (take) begin
        drn_sel <= rd_sel;
        // The other half is next in line
        rd_sel  <= ~rd_sel;
        rd_ptr  <= '0;
      end else if (draining && i_rd_stb) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

// ==== hw/ppfifo_pkg.sv ====
package ppfifo_pkg;

  // Life cycle of one FIFO half
  typedef enum logic [1:0] {
    EMPTY    = 2'd0,
    FILLING  = 2'd1,
    FULL     = 2'd2,
    DRAINING = 2'd3
  } half_state_t;

endpackage

// ==== hw/reader_pkg.sv ====
package reader_pkg;

  // Reader FSM states
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    GET_BLOCK = 2'd1,
    READ_DATA = 2'd2,
    FINISHED  = 2'd3
  } reader_state_t;

  // Memory bank selector
  typedef enum logic {
    BANK0 = 1'b0,
    BANK1 = 1'b1
  } bank_t;

endpackage

// ==== hw/wb_sram.sv ====
`timescale 1ns/1ps
`include "m2f_defines.svh"

module wb_sram (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_host_we,
  input  logic [`M2F_ADDR_W-1:0] i_host_adr,
  input  logic [`M2F_DATA_W-1:0] i_host_dat,
  input  logic                   i_cyc,
  input  logic                   i_stb,
  input  logic [`M2F_ADDR_W-1:0] i_adr,
  output logic [`M2F_DATA_W-1:0] o_dat,
  output logic                   o_ack
);

  logic [`M2F_DATA_W-1:0]              mem [`M2F_MEM_WORDS];
  logic [$clog2(`M2F_MEM_WORDS)-1:0]   wr_idx;
  logic [$clog2(`M2F_MEM_WORDS)-1:0]   rd_idx;
  logic                                rd_req;

  // Only the low address bits select a word
  assign wr_idx = i_host_adr[$clog2(`M2F_MEM_WORDS)-1:0];
  assign rd_idx = i_adr[$clog2(`M2F_MEM_WORDS)-1:0];

  // New request only when no ack is already out
  assign rd_req = i_cyc && i_stb && !o_ack;

  // Host port
  always_ff @(posedge clk) begin
    if (i_host_we) begin
      mem[wr_idx] <= i_host_dat;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_req) begin
      o_dat <= mem[rd_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_ack <= 1'b0;
    end else begin
      o_ack <= rd_req;
    end
  end

endmodule

// ==== sim.f ====
+incdir+hw
hw/reader_pkg.sv
hw/ppfifo_pkg.sv
hw/bank_tracker.sv
hw/mem_reader_fsm.sv
hw/ppfifo.sv
hw/wb_sram.sv
hw/mem_2_ppfifo_top.sv
sim/tb_clkgen.sv
sim/mem_2_ppfifo_properties.sv
sim/tb_mem_2_ppfifo.sv

// ==== sim/mem_2_ppfifo_properties.sv ====
`timescale 1ns/1ps

module mem_2_ppfifo_properties (
  input logic                      clk,
  input logic                      rst,
  input logic [1:0]                fifo_rdy,
  input logic [1:0]                fifo_act,
  input logic                      fifo_stb,
  input logic                      mem_stb,
  input logic                      mem_ack,
  input logic                      read_finished,
  input reader_pkg::reader_state_t state
);

  // FIFO writes only go to exactly one claimed half
  a_stb_onehot: assert property (@(posedge clk) disable iff (rst)
    fifo_stb |-> $onehot(fifo_act))
    else $error("FIFO write strobe without a single active half");

  // A new activate starts from zero, is one-hot and names a free half
  a_claim_free: assert property (@(posedge clk) disable iff (rst)
    ((fifo_act != $past(fifo_act)) && (fifo_act != 2'b00)) |->
      (($past(fifo_act) == 2'b00) && $onehot(fifo_act) &&
       ((fifo_act & ~$past(fifo_rdy)) == 2'b00)))
    else $error("FIFO activate is not a single claim of a free half");

  // Memory answers one cycle after a strobe
  a_ack_after_stb: assert property (@(posedge clk) disable iff (rst)
    mem_ack |-> $past(mem_stb))
    else $error("Memory ack without a preceding strobe");

  a_finished_pulse: assert property (@(posedge clk) disable iff (rst)
    read_finished |=> !read_finished)
    else $error("Read finished held longer than one cycle");

  // No claimed half means the bus stays quiet
  a_wait_no_stb: assert property (@(posedge clk) disable iff (rst)
    ((state == reader_pkg::READ_DATA) && (fifo_act == 2'b00)) |-> !mem_stb)
    else $error("Memory strobe high while no FIFO half is claimed");

endmodule

bind mem_2_ppfifo_top mem_2_ppfifo_properties props0 (
  .clk(clk),
  .rst(rst),
  .fifo_rdy(fifo_rdy),
  .fifo_act(fifo_act),
  .fifo_stb(fifo_stb),
  .mem_stb(mem_stb),
  .mem_ack(mem_ack),
  .read_finished(o_read_finished),
  .state(reader0.state)
);

// ==== sim/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk,
  output logic rst
);

  // 100 ns clock period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reset held for five rising edges, released just after the edge
  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    #10 rst = 1'b0;
  end

endmodule

// ==== sim/tb_mem_2_ppfifo.sv ====
`timescale 1ns/1ps
`include "m2f_defines.svh"

module tb_mem_2_ppfifo;

  localparam int N_ROWS = 5;

  typedef struct packed {
    logic        en;
    logic [31:0] b0_base;
    logic [31:0] b0_size;
    logic [31:0] b1_base;
    logic [31:0] b1_size;
    logic [1:0]  newp;
    logic [31:0] fins;
    logic [31:0] words;
    logic [31:0] hold;
  } row_t;

  logic clk;
  logic rst;
  logic i_enable;
  logic i_host_we;
  logic [`M2F_ADDR_W-1:0] i_host_adr;
  logic [`M2F_DATA_W-1:0] i_host_dat;
  logic [`M2F_ADDR_W-1:0] i_mem0_base;
  logic [`M2F_ADDR_W-1:0] i_mem0_size;
  logic i_mem0_new;
  logic [`M2F_ADDR_W-1:0] i_mem1_base;
  logic [`M2F_ADDR_W-1:0] i_mem1_size;
  logic i_mem1_new;
  logic [`M2F_ADDR_W-1:0] o_mem0_count;
  logic [`M2F_ADDR_W-1:0] o_mem1_count;
  logic o_mem0_empty;
  logic o_mem1_empty;
  logic o_read_finished;
  logic i_rd_act;
  logic i_rd_stb;
  logic o_rd_ready;
  logic [`M2F_HALF_LOG2:0] o_rd_size;
  logic [`M2F_DATA_W-1:0] o_rd_data;

  row_t        tbl [N_ROWS];
  logic [31:0] model [`M2F_MEM_WORDS];
  logic [31:0] lfsr;
  int          fin_total;
  int          exp_words [$];
  int          exp_halves [$];

  tb_clkgen clkgen0 (.clk(clk), .rst(rst));

  mem_2_ppfifo_top dut0 (.*);

  // Stimulus table columns are enable, bank 0, bank 1, new pulses, finishes, words and hold-off
  initial begin
    tbl[0] = '{1'b1, 32'd16, 32'd20, 32'd0, 32'd0, 2'b01, 32'd1, 32'd20, 32'd100};
    tbl[1] = '{1'b1, 32'd40, 32'd10, 32'd100, 32'd13, 2'b11, 32'd2, 32'd23, 32'd0};
    tbl[2] = '{1'b1, 32'd40, 32'd10, 32'd100, 32'd13, 2'b01, 32'd1, 32'd10, 32'd0};
    tbl[3] = '{1'b0, 32'd200, 32'd12, 32'd100, 32'd13, 2'b01, 32'd0, 32'd0, 32'd40};
    // Bank runs past the top of memory and wraps
    tbl[4] = '{1'b1, 32'd250, 32'd12, 32'd100, 32'd13, 2'b01, 32'd1, 32'd12, 32'd0};
  end

  always @(posedge clk) begin
    if (!rst && o_read_finished) begin
      fin_total <= fin_total + 1;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] w;
    w = '0;
    for (int b = 0; b < 32; b++) begin
      lfsr = lfsr_next(lfsr);
      w[b] = lfsr[0];
    end
    return w;
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic step();
    @(posedge clk);
    #10;
  endtask

  task automatic load_memory();
    for (int a = 0; a < `M2F_MEM_WORDS; a++) begin
      i_host_we  = 1'b1;
      i_host_adr = a;
      i_host_dat = random_word();
      model[a]   = i_host_dat;
      step();
    end
    i_host_we = 1'b0;
  endtask

  // Blocks go bank 0 then bank 1, each split into halves of at most 8 words
  task automatic build_expect(input row_t r);
    int base;
    int size;
    int left;
    for (int b = 0; b < 2; b++) begin
      base = (b == 0) ? r.b0_base : r.b1_base;
      size = (b == 0) ? r.b0_size : r.b1_size;
      if (r.en && r.newp[b]) begin
        for (int i = 0; i < size; i++) begin
          exp_words.push_back(model[(base + i) % `M2F_MEM_WORDS]);
        end
        left = size;
        while (left > 0) begin
          exp_halves.push_back((left > `M2F_HALF_DEPTH) ? `M2F_HALF_DEPTH : left);
          left = left - `M2F_HALF_DEPTH;
        end
      end
    end
  endtask

  task automatic drain_halves();
    int hsize;
    while (exp_halves.size() > 0) begin
      while (!o_rd_ready) begin
        step();
      end
      hsize = exp_halves.pop_front();
      check_val("half size", o_rd_size, hsize);
      i_rd_act = 1'b1;
      step();
      for (int i = 0; i < hsize; i++) begin
        check_val("drain data", o_rd_data, exp_words.pop_front());
        i_rd_stb = 1'b1;
        step();
      end
      i_rd_stb = 1'b0;
      i_rd_act = 1'b0;
      step();
    end
  endtask

  // Watchdog scaled by the words in the table
  initial begin
    longint limit;
    #1;
    limit = 2000 + N_ROWS * 600;
    for (int r = 0; r < N_ROWS; r++) begin
      limit = limit + tbl[r].words * 10;
    end
    #(limit * 100);
    $display("Timeout: the DUT stopped making progress before the tests completed");
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int fin_start;
    i_enable    = 1'b0;
    i_host_we   = 1'b0;
    i_host_adr  = '0;
    i_host_dat  = '0;
    i_mem0_base = '0;
    i_mem0_size = '0;
    i_mem0_new  = 1'b0;
    i_mem1_base = '0;
    i_mem1_size = '0;
    i_mem1_new  = 1'b0;
    i_rd_act    = 1'b0;
    i_rd_stb    = 1'b0;
    fin_total   = 0;
    lfsr        = 32'hc56466a7;
    wait (rst === 1'b0);
    step();

    for (int r = 0; r < N_ROWS; r++) begin
      load_memory();
      build_expect(tbl[r]);
      check_val("table word count", exp_words.size(), tbl[r].words);
      fin_start   = fin_total;
      i_enable    = tbl[r].en;
      i_mem0_base = tbl[r].b0_base;
      i_mem0_size = tbl[r].b0_size;
      i_mem1_base = tbl[r].b1_base;
      i_mem1_size = tbl[r].b1_size;
      i_mem0_new  = tbl[r].newp[0];
      i_mem1_new  = tbl[r].newp[1];
      step();
      i_mem0_new = 1'b0;
      i_mem1_new = 1'b0;

      // Hold off the drain so the reader runs out of free halves
      repeat (tbl[r].hold) begin
        if (!tbl[r].en) begin
          check_val("rd_ready while disabled", o_rd_ready, 1'b0);
        end
        step();
      end

      // Two undrained halves stop the reader two halves into bank 0
      if (tbl[r].en && (tbl[r].hold != 0)) begin
        check_val("bank 0 count while held", o_mem0_count,
                  tbl[r].b0_size - 2 * `M2F_HALF_DEPTH);
      end

      drain_halves();
      repeat (6) step();

      check_val("finished pulses", fin_total - fin_start, tbl[r].fins);
      if (tbl[r].en) begin
        check_val("bank 0 count", o_mem0_count, 0);
        check_val("bank 1 count", o_mem1_count, 0);
        check_val("bank 0 empty", o_mem0_empty, 1'b1);
        check_val("bank 1 empty", o_mem1_empty, 1'b1);
      end else begin
        check_val("bank 0 count", o_mem0_count, tbl[r].b0_size);
        check_val("rd_ready while disabled", o_rd_ready, 1'b0);
      end
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
